//--- src/lcd_defines.svh
`ifndef LCD_DEFINES_SVH
`define LCD_DEFINES_SVH

// Field widths
`define LCD_DATA_W 8
`define LCD_CNT_W  20   // Holds 100 ms at 8 MHz

//////////////////////////////////////////////////////////////////////
// HD44780 command bytes
//////////////////////////////////////////////////////////////////////
`define LCD_CMD_WAKE     8'h30  // Function set, wake-up form
`define LCD_CMD_SETUP    8'h38  // 8-bit bus, 2 lines, 5x7 font
`define LCD_CMD_DISP_OFF 8'h08
`define LCD_CMD_CLEAR    8'h01
`define LCD_CMD_ENTRY    8'h06  // Cursor moves right, no shift
`define LCD_CMD_DISP_ON  8'h0C  // Display on, cursor off

//////////////////////////////////////////////////////////////////////
// Delays in nanoseconds
//////////////////////////////////////////////////////////////////////
`define LCD_T_SETUP_NS  32'd40           // RS and data ahead of E
`define LCD_T_PULSE_NS  32'd250          // E high time
`define LCD_T_42US_NS   32'd42_000
`define LCD_T_60US_NS   32'd60_000
`define LCD_T_100US_NS  32'd100_000
`define LCD_T_5MS_NS    32'd5_000_000    // Clear and first wake-up
`define LCD_T_100MS_NS  32'd100_000_000  // Power-up wait

`endif

//--- src/lcd_pkg.sv
package lcd_pkg;

  // Host operation codes
  typedef enum logic [1:0] {
    OP_IDLE       = 2'd0,
    OP_WRITE_CHAR = 2'd1,  // RS high
    OP_REINIT     = 2'd2,
    OP_WRITE_CMD  = 2'd3   // RS low
  } lcd_op_e;

  // Delay classes handled by the delay timer
  typedef enum logic [2:0] {
    DLY_SETUP,   // 40 ns
    DLY_PULSE,   // 250 ns
    DLY_42US,
    DLY_60US,
    DLY_100US,
    DLY_5MS,
    DLY_100MS
  } lcd_delay_e;

endpackage

//--- src/lcd_xfer_if.sv
`timescale 1ns/100ps
`include "lcd_defines.svh"

// One byte transfer on the LCD bus and its completion
interface lcd_xfer_if;
  import lcd_pkg::*;

  logic                   req;   // One-cycle request strobe
  logic                   rs;
  logic [`LCD_DATA_W-1:0] data;
  lcd_delay_e             post;  // Settle time after E falls
  logic                   done;  // One-cycle completion strobe

  modport master (
    output req, rs, data, post,
    input  done
  );

  modport slave (
    input  req, rs, data, post,
    output done
  );

endinterface

//--- src/lcd_delay_timer.sv
`timescale 1ns/100ps
`include "lcd_defines.svh"

module lcd_delay_timer #(
  parameter integer CLK_FREQ = 8000000
) (
  input  logic                clk_i,
  input  logic                flag_rst,
  input  logic                start_i,
  input  lcd_pkg::lcd_delay_e sel_i,
  output logic                done_o
);
  import lcd_pkg::*;

  // Round up, never below one cycle
  function automatic logic [`LCD_CNT_W-1:0] ns_to_cycles(input longint unsigned ns);
    longint unsigned cyc;
    cyc = (ns * longint'(CLK_FREQ) + 64'd999_999_999) / 64'd1_000_000_000;
    if (cyc == 0) begin
      cyc = 1;
    end
    return cyc[`LCD_CNT_W-1:0];
  endfunction

  localparam logic [`LCD_CNT_W-1:0] N_SETUP = ns_to_cycles(`LCD_T_SETUP_NS);
  localparam logic [`LCD_CNT_W-1:0] N_PULSE = ns_to_cycles(`LCD_T_PULSE_NS);
  localparam logic [`LCD_CNT_W-1:0] N_42US  = ns_to_cycles(`LCD_T_42US_NS);
  localparam logic [`LCD_CNT_W-1:0] N_60US  = ns_to_cycles(`LCD_T_60US_NS);
  localparam logic [`LCD_CNT_W-1:0] N_100US = ns_to_cycles(`LCD_T_100US_NS);
  localparam logic [`LCD_CNT_W-1:0] N_5MS   = ns_to_cycles(`LCD_T_5MS_NS);
  localparam logic [`LCD_CNT_W-1:0] N_100MS = ns_to_cycles(`LCD_T_100MS_NS);

  logic [`LCD_CNT_W-1:0] load;
  logic [`LCD_CNT_W-1:0] cnt;   // Zero when idle

  always_comb begin
    case (sel_i)
      DLY_SETUP: load = N_SETUP;
      DLY_PULSE: load = N_PULSE;
      DLY_42US:  load = N_42US;
      DLY_60US:  load = N_60US;
      DLY_100US: load = N_100US;
      DLY_5MS:   load = N_5MS;
      default:   load = N_100MS;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (flag_rst) begin
      cnt    <= '0;
      done_o <= 1'b0;
    end else if (start_i) begin
      cnt    <= load;   // Restart even if running
      done_o <= 1'b0;
    end else begin
      done_o <= (cnt == 1);
      if (cnt != 0) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

endmodule

//--- src/lcd_bus_cycle.sv
`timescale 1ns/100ps
`include "lcd_defines.svh"

module lcd_bus_cycle #(
  parameter integer CLK_FREQ = 8000000
) (
  input  logic                   clk_i,
  input  logic                   flag_rst,
  lcd_xfer_if.slave              xfer,
  output logic                   lcd_rs_o,
  output logic                   lcd_e_o,
  output logic [`LCD_DATA_W-1:0] lcd_data_o
);
  import lcd_pkg::*;

  typedef enum logic [1:0] {PH_IDLE, PH_SETUP, PH_PULSE, PH_POST} phase_e;

  phase_e     phase;
  lcd_delay_e post_q;
  lcd_delay_e tmr_sel;
  logic       tmr_start;
  logic       tmr_done;

  //////////////////////////////////////////////////////////////////////
  // One timer serves all three phases
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (phase)
      PH_IDLE:  tmr_sel = DLY_SETUP;
      PH_SETUP: tmr_sel = DLY_PULSE;
      default:  tmr_sel = post_q;
    endcase
  end

  // Next phase's timer starts as the current one expires
  assign tmr_start = (phase == PH_IDLE) ? xfer.req : (tmr_done && phase != PH_POST);

  lcd_delay_timer #(.CLK_FREQ(CLK_FREQ)) u_tmr (
    .clk_i    (clk_i),
    .flag_rst (flag_rst),
    .start_i  (tmr_start),
    .sel_i    (tmr_sel),
    .done_o   (tmr_done)
  );

  //////////////////////////////////////////////////////////////////////
  // Phase sequencing and E pulse
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (flag_rst) begin
      phase     <= PH_IDLE;
      lcd_e_o   <= 1'b0;
      xfer.done <= 1'b0;
    end else begin
      xfer.done <= 1'b0;
      case (phase)
        PH_IDLE:  if (xfer.req) phase <= PH_SETUP;
        PH_SETUP: if (tmr_done) begin
          lcd_e_o <= 1'b1;
          phase   <= PH_PULSE;
        end
        PH_PULSE: if (tmr_done) begin
          lcd_e_o <= 1'b0;   // LCD latches on this edge
          phase   <= PH_POST;
        end
        default:  if (tmr_done) begin
          xfer.done <= 1'b1;
          phase     <= PH_IDLE;
        end
      endcase
    end
  end

  // Bus stays put until the next request
  always_ff @(posedge clk_i) begin
    if (phase == PH_IDLE && xfer.req) begin
      lcd_rs_o   <= xfer.rs;
      lcd_data_o <= xfer.data;
      post_q     <= xfer.post;
    end
  end

endmodule

//--- src/lcd_init_seq.sv
`timescale 1ns/100ps
`include "lcd_defines.svh"

module lcd_init_seq #(
  parameter integer CLK_FREQ = 8000000
) (
  input  logic       clk_i,
  input  logic       flag_rst,
  input  logic       start_i,
  output logic       done_o,
  lcd_xfer_if.master xfer
);
  import lcd_pkg::*;

  typedef enum logic [1:0] {IS_IDLE, IS_WAIT, IS_SEND} state_e;

  state_e     state;
  logic [2:0] step;      // Table index
  logic       pwr_done;

  // Power-up wait has a timer of its own
  lcd_delay_timer #(.CLK_FREQ(CLK_FREQ)) u_pwr_tmr (
    .clk_i    (clk_i),
    .flag_rst (flag_rst),
    .start_i  (start_i),
    .sel_i    (DLY_100MS),
    .done_o   (pwr_done)
  );

  //////////////////////////////////////////////////////////////////////
  // Command table with post-delays
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    xfer.rs = 1'b0;   // Every init byte is an instruction
    case (step)
      3'd0: begin xfer.data = `LCD_CMD_WAKE;     xfer.post = DLY_5MS;   end
      3'd1: begin xfer.data = `LCD_CMD_WAKE;     xfer.post = DLY_100US; end
      3'd2: begin xfer.data = `LCD_CMD_WAKE;     xfer.post = DLY_100US; end
      3'd3: begin xfer.data = `LCD_CMD_SETUP;    xfer.post = DLY_100US; end
      3'd4: begin xfer.data = `LCD_CMD_DISP_OFF; xfer.post = DLY_60US;  end
      3'd5: begin xfer.data = `LCD_CMD_CLEAR;    xfer.post = DLY_5MS;   end
      3'd6: begin xfer.data = `LCD_CMD_ENTRY;    xfer.post = DLY_60US;  end
      default: begin
        xfer.data = `LCD_CMD_DISP_ON;
        xfer.post = DLY_60US;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Step through the table
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (flag_rst) begin
      state    <= IS_IDLE;
      step     <= '0;
      xfer.req <= 1'b0;
      done_o   <= 1'b0;
    end else begin
      xfer.req <= 1'b0;
      done_o   <= 1'b0;
      if (start_i) begin
        state <= IS_WAIT;   // Restart from anywhere
        step  <= '0;
      end else begin
        case (state)
          IS_WAIT: if (pwr_done) begin
            xfer.req <= 1'b1;
            state    <= IS_SEND;
          end
          IS_SEND: if (xfer.done) begin
            if (step == 3'd7) begin
              done_o <= 1'b1;
              state  <= IS_IDLE;
            end else begin
              step     <= step + 1'b1;
              xfer.req <= 1'b1;  // Next byte lines up with the new step
            end
          end
          default: ;
        endcase
      end
    end
  end

endmodule

//--- src/lcd_host_ctrl.sv
`timescale 1ns/100ps
`include "lcd_defines.svh"

module lcd_host_ctrl (
  input  logic                   clk_i,
  input  logic                   flag_rst,
  input  lcd_pkg::lcd_op_e       ops_i,
  input  logic [`LCD_DATA_W-1:0] data_i,
  input  logic                   enb_i,
  output logic                   rdy_o,
  output logic                   init_start_o,
  input  logic                   init_done_i,
  lcd_xfer_if.slave              init_xfer,
  lcd_xfer_if.master             bus_xfer
);
  import lcd_pkg::*;

  typedef enum logic [1:0] {ST_INIT, ST_IDLE, ST_WRITE} state_e;

  state_e                 state;
  logic                   wr_req;
  logic                   wr_rs;
  logic [`LCD_DATA_W-1:0] wr_data;

  assign rdy_o = (state == ST_IDLE);

  //////////////////////////////////////////////////////////////////////
  // Main FSM
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (flag_rst) begin
      state        <= ST_INIT;
      init_start_o <= 1'b1;   // Init kicks off as reset drops
      wr_req       <= 1'b0;
    end else begin
      init_start_o <= 1'b0;
      wr_req       <= 1'b0;
      case (state)
        ST_INIT: if (init_done_i) state <= ST_IDLE;
        ST_IDLE: if (enb_i) begin
          case (ops_i)
            OP_WRITE_CHAR, OP_WRITE_CMD: begin
              wr_req <= 1'b1;
              state  <= ST_WRITE;
            end
            OP_REINIT: begin
              init_start_o <= 1'b1;
              state        <= ST_INIT;
            end
            default: ;   // OP_IDLE
          endcase
        end
        ST_WRITE: if (bus_xfer.done) state <= ST_IDLE;
        default:  state <= ST_INIT;
      endcase
    end
  end

  // Host byte and RS held for the write
  always_ff @(posedge clk_i) begin
    if (state == ST_IDLE && enb_i) begin
      wr_data <= data_i;
      wr_rs   <= (ops_i == OP_WRITE_CHAR);
    end
  end

  // Bus ownership
  always_comb begin
    if (state == ST_INIT) begin
      bus_xfer.req   = init_xfer.req;
      bus_xfer.rs    = init_xfer.rs;
      bus_xfer.data  = init_xfer.data;
      bus_xfer.post  = init_xfer.post;
      init_xfer.done = bus_xfer.done;
    end else begin
      bus_xfer.req   = wr_req;
      bus_xfer.rs    = wr_rs;
      bus_xfer.data  = wr_data;
      bus_xfer.post  = DLY_42US;
      init_xfer.done = 1'b0;
    end
  end

endmodule

//--- src/lcd16x2.sv
`timescale 1ns/100ps
`include "lcd_defines.svh"

module lcd16x2 #(
  parameter integer CLK_FREQ = 8000000   // Hz
) (
  input  logic                   clk_i,
  input  logic                   flag_rst,
  input  logic [`LCD_DATA_W-1:0] data_i,
  input  logic [1:0]             ops_i,
  input  logic                   enb_i,
  output logic                   rdy_o,
  output logic                   lcd_rs_o,
  output logic                   lcd_e_o,
  output logic [`LCD_DATA_W-1:0] lcd_data_o
);
  import lcd_pkg::*;

  logic init_start;
  logic init_done;

  lcd_xfer_if init_xfer ();   // Init table to FSM
  lcd_xfer_if bus_xfer ();    // FSM to bus driver

  lcd_host_ctrl u_host (
    .clk_i        (clk_i),
    .flag_rst     (flag_rst),
    .ops_i        (lcd_op_e'(ops_i)),
    .data_i       (data_i),
    .enb_i        (enb_i),
    .rdy_o        (rdy_o),
    .init_start_o (init_start),
    .init_done_i  (init_done),
    .init_xfer    (init_xfer.slave),
    .bus_xfer     (bus_xfer.master)
  );

  lcd_init_seq #(.CLK_FREQ(CLK_FREQ)) u_init (
    .clk_i    (clk_i),
    .flag_rst (flag_rst),
    .start_i  (init_start),
    .done_o   (init_done),
    .xfer     (init_xfer.master)
  );

  lcd_bus_cycle #(.CLK_FREQ(CLK_FREQ)) u_bus (
    .clk_i      (clk_i),
    .flag_rst   (flag_rst),
    .xfer       (bus_xfer.slave),
    .lcd_rs_o   (lcd_rs_o),
    .lcd_e_o    (lcd_e_o),
    .lcd_data_o (lcd_data_o)
  );

endmodule

//--- tb/tb_lcd16x2.sv
`timescale 1ns/100ps

module tb_lcd16x2;

  localparam integer CLK_HZ = 1000000;   // Clock rate the DUT is told about
  localparam integer CLK_NS = 20;

  localparam logic [1:0] OP_IDLE   = 2'd0;
  localparam logic [1:0] OP_CHAR   = 2'd1;
  localparam logic [1:0] OP_REINIT = 2'd2;
  localparam logic [1:0] OP_CMD    = 2'd3;

  // Delay in whole cycles rounded up to at least one
  function automatic longint ns_cycles(input longint ns);
    longint c;
    c = (ns * CLK_HZ + 64'd999_999_999) / 64'd1_000_000_000;
    if (c < 1) begin
      c = 1;
    end
    return c;
  endfunction

  localparam longint N_PULSE  = ns_cycles(250);
  localparam longint N_42US   = ns_cycles(42_000);
  localparam longint N_60US   = ns_cycles(60_000);
  localparam longint N_100US  = ns_cycles(100_000);
  localparam longint N_5MS    = ns_cycles(5_000_000);
  localparam longint N_100MS  = ns_cycles(100_000_000);
  localparam longint INIT_CYC = N_100MS + 2 * N_5MS + 3 * N_100US + 3 * N_60US + 128;
  localparam longint WR_CYC   = N_42US + 32;   // One host write with slack
  localparam longint NO_VALUE = 64'h7fff_ffff_ffff_ffff;

  logic       clk_i;
  logic       flag_rst;
  logic [7:0] data_i;
  logic [1:0] ops_i;
  logic       enb_i;
  logic       rdy_o;
  logic       lcd_rs_o;
  logic       lcd_e_o;
  logic [7:0] lcd_data_o;

  int         errors = 0;
  int         checks = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  int         seed;
  logic [8:0] seen[$];             // {rs, data} at each E fall
  time        fall_at[$];
  time        rise_at;
  logic [8:0] rise_val;
  logic       e_open = 1'b0;
  longint     min_high = NO_VALUE;   // Shortest E-high time in cycles
  longint     min_clear_gap = NO_VALUE;

  lcd16x2 #(.CLK_FREQ(CLK_HZ)) dut0 (
    .clk_i      (clk_i),
    .flag_rst   (flag_rst),
    .data_i     (data_i),
    .ops_i      (ops_i),
    .enb_i      (enb_i),
    .rdy_o      (rdy_o),
    .lcd_rs_o   (lcd_rs_o),
    .lcd_e_o    (lcd_e_o),
    .lcd_data_o (lcd_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_NS / 2) clk_i = ~clk_i;
  end

  ///////////////////////////////////////////////////////////////////////
  // Check helpers
  ///////////////////////////////////////////////////////////////////////
  task automatic compare_hex(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      $display("[FAIL] %s expected 0x%0h got 0x%0h at %0t", name, exp, act, $time);
      errors++;
    end
  endtask

  task automatic confirm(input bit ok, input string what);
    checks++;
    assert (ok) else begin
      $display("Error at %0t: %s", $time, what);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d error(s)", name, errors - err0);
    end
  endtask

  ///////////////////////////////////////////////////////////////////////
  // Bus monitor
  ///////////////////////////////////////////////////////////////////////
  always @(posedge lcd_e_o) begin
    rise_at  = $time;
    rise_val = {lcd_rs_o, lcd_data_o};
    e_open   = 1'b1;
  end

  always @(negedge lcd_e_o) begin
    if (e_open) begin   // Skips the first X to 0 at reset
      e_open = 1'b0;
      compare_hex("lcd_rs_o/lcd_data_o while E high", 32'(rise_val), 32'({lcd_rs_o, lcd_data_o}));
      if (($time - rise_at) / CLK_NS < min_high) begin
        min_high = ($time - rise_at) / CLK_NS;
      end
      seen.push_back({lcd_rs_o, lcd_data_o});
      fall_at.push_back($time);
    end
  end

  // Expected initialization bytes in order
  function automatic logic [7:0] init_byte(input int idx);
    case (idx)
      0, 1, 2: return 8'h30;
      3:       return 8'h38;
      4:       return 8'h08;
      5:       return 8'h01;
      6:       return 8'h06;
      default: return 8'h0C;
    endcase
  endfunction

  task automatic send_op(input logic [1:0] op, input logic [7:0] d, input logic en);
    @(posedge clk_i);
    ops_i  <= op;
    data_i <= d;
    enb_i  <= en;
    @(posedge clk_i);
    ops_i  <= OP_IDLE;
    enb_i  <= 1'b0;
  endtask

  task automatic wait_rdy(input longint limit, output longint waited);
    waited = 0;
    while (rdy_o !== 1'b1 && waited < limit) begin
      @(negedge clk_i);
      waited++;
    end
    confirm(rdy_o === 1'b1, "rdy_o did not return high within the expected time");
  endtask

  task automatic clear_monitor();
    seen.delete();
    fall_at.delete();
  endtask

  // Call at a negedge with rdy_o low and the monitor cleared
  task automatic expect_init();
    longint waited;
    longint gap;
    int     i;
    wait_rdy(2 * INIT_CYC, waited);
    confirm(waited >= N_100MS, "rdy_o rose before the power-up wait was over");
    compare_hex("lcd_e_o pulses in init", 32'd8, 32'(seen.size()));
    for (i = 0; i < 8 && i < seen.size(); i++) begin
      compare_hex("lcd_rs_o", 32'd0, 32'(seen[i][8]));
      compare_hex("lcd_data_o", 32'(init_byte(i)), 32'(seen[i][7:0]));
    end
    if (fall_at.size() >= 7) begin
      gap = (fall_at[6] - fall_at[5]) / CLK_NS;   // Clear to entry mode
      if (gap < min_clear_gap) begin
        min_clear_gap = gap;
      end
    end
  endtask

  task automatic one_write(input logic [1:0] op, input logic [7:0] d, input logic exp_rs);
    int     base;
    longint waited;
    base = seen.size();
    send_op(op, d, 1'b1);
    @(negedge clk_i);
    compare_hex("rdy_o", 32'd0, 32'(rdy_o));
    wait_rdy(WR_CYC, waited);
    compare_hex("lcd_e_o pulses per write", 32'(base + 1), 32'(seen.size()));
    if (seen.size() > base) begin
      compare_hex("lcd_rs_o", 32'(exp_rs), 32'(seen[base][8]));
      compare_hex("lcd_data_o", 32'(d), 32'(seen[base][7:0]));
    end
  endtask

  ///////////////////////////////////////////////////////////////////////
  // Directed tests
  ///////////////////////////////////////////////////////////////////////
  task automatic power_up_init();
    int err0;
    err0 = errors;
    @(negedge clk_i);
    compare_hex("rdy_o", 32'd0, 32'(rdy_o));
    expect_init();
    finish_test("power-up init", err0);
  endtask

  task automatic char_writes();
    int         err0;
    logic [7:0] d;
    err0 = errors;
    repeat (10) begin
      d = 8'($random(seed));
      one_write(OP_CHAR, d, 1'b1);
    end
    finish_test("character writes", err0);
  endtask

  task automatic cmd_writes();
    int         err0;
    logic [7:0] d;
    err0 = errors;
    repeat (10) begin
      d = 8'($random(seed));
      one_write(OP_CMD, d, 1'b0);
    end
    finish_test("instruction writes", err0);
  endtask

  task automatic ignored_requests();
    int         err0;
    int         base;
    int         low;
    longint     waited;
    logic [7:0] d;
    err0 = errors;
    base = seen.size();
    send_op(OP_IDLE, 8'hA5, 1'b1);
    send_op(OP_CHAR, 8'h5A, 1'b0);
    send_op(OP_REINIT, 8'h00, 1'b0);
    send_op(OP_CMD, 8'hC3, 1'b0);
    low = 0;
    repeat (200) begin
      @(negedge clk_i);
      if (rdy_o !== 1'b1) low++;
    end
    compare_hex("rdy_o low cycles", 32'd0, 32'(low));
    compare_hex("lcd_e_o pulses while ignored", 32'(base), 32'(seen.size()));
    // Second request lands while the first write is busy
    d = 8'($random(seed));
    send_op(OP_CHAR, d, 1'b1);
    repeat (3) @(posedge clk_i);
    send_op(OP_CMD, ~d, 1'b1);
    @(negedge clk_i);
    wait_rdy(WR_CYC, waited);
    repeat (100) @(negedge clk_i);
    compare_hex("lcd_e_o pulses while busy", 32'(base + 1), 32'(seen.size()));
    if (seen.size() > base) begin
      compare_hex("lcd_data_o", 32'(d), 32'(seen[base][7:0]));
    end
    finish_test("ignored requests", err0);
  endtask

  task automatic reinit();
    int         err0;
    longint     waited;
    logic [7:0] d;
    err0 = errors;
    clear_monitor();
    send_op(OP_REINIT, 8'h00, 1'b1);
    @(negedge clk_i);
    compare_hex("rdy_o", 32'd0, 32'(rdy_o));
    expect_init();
    // Reset during the settle time of a write
    clear_monitor();
    d = 8'($random(seed));
    send_op(OP_CHAR, d, 1'b1);
    waited = 0;
    while (seen.size() == 0 && waited < WR_CYC) begin
      @(negedge clk_i);
      waited++;
    end
    confirm(seen.size() == 1, "the write before the reset gave no E pulse");
    confirm(rdy_o === 1'b0, "the write finished before the reset could be applied");
    @(posedge clk_i);
    flag_rst <= 1'b1;
    repeat (5) @(posedge clk_i);
    flag_rst <= 1'b0;
    clear_monitor();
    @(negedge clk_i);
    compare_hex("rdy_o", 32'd0, 32'(rdy_o));
    expect_init();
    finish_test("re-initialization", err0);
  endtask

  task automatic pulse_width();
    int err0;
    err0 = errors;
    confirm(min_high != NO_VALUE, "no E pulse was measured");
    confirm(min_high >= N_PULSE,
            $sformatf("E was high for %0d cycles, below %0d", min_high, N_PULSE));
    confirm(min_clear_gap != NO_VALUE, "no clear to entry mode gap was measured");
    confirm(min_clear_gap >= N_5MS,
            $sformatf("clear to entry mode gap of %0d cycles, below %0d", min_clear_gap, N_5MS));
    finish_test("pulse width", err0);
  endtask

  ///////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ///////////////////////////////////////////////////////////////////////
  initial begin
    seed     = 36603;
    flag_rst = 1'b1;
    enb_i    = 1'b0;
    ops_i    = OP_IDLE;
    data_i   = 8'h00;
    repeat (5) @(posedge clk_i);
    flag_rst <= 1'b0;
    power_up_init();
    char_writes();
    cmd_writes();
    ignored_requests();
    reinit();
    pulse_width();
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Twice the time of three init sequences and 50 writes
  initial begin
    repeat (2 * (3 * INIT_CYC + 50 * WR_CYC)) @(posedge clk_i);
    $display("Timeout: the tests did not finish in the allowed number of clock cycles");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- build.f
+incdir+src
src/lcd_pkg.sv
src/lcd_xfer_if.sv
src/lcd_delay_timer.sv
src/lcd_bus_cycle.sv
src/lcd_init_seq.sv
src/lcd_host_ctrl.sv
src/lcd16x2.sv
tb/tb_lcd16x2.sv

//--- run_sim.sh
#!/bin/sh
# Compile the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_lcd16x2 -o tb_lcd16x2 &&
  ./obj_dir/tb_lcd16x2 | tee /dev/stderr | grep -q "STATUS: PASS" &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
